/* acq_pkg.sv */
package acq_pkg;

  localparam int NUM_CH    = 4;                   // Event channels
  localparam int CNT_W     = 16;                  // Event counter width
  localparam int WIN_W     = 20;                  // Window length width
  localparam int RUNS_W    = 8;                   // Completed run counter width
  localparam int STS_WORDS = 8;                   // Status words in the bank
  localparam int STS_SEL_W = $clog2(STS_WORDS);   // Word select width
  localparam int WORD_W    = 32;                  // Status word width

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } acq_state_e;

  // Word 0, state in 1:0 and run count in 23:16
  typedef struct packed {
    logic [WORD_W-16-RUNS_W-1:0] rsvd_hi;
    logic [RUNS_W-1:0]           run_count;
    logic [13:0]                 rsvd_lo;
    acq_state_e                  state;
  } acq_ctrl_word_t;

  typedef struct packed {
    logic [WORD_W-NUM_CH-1:0] rsvd;
    logic [NUM_CH-1:0]        flags;            // Sticky overflow per channel
  } acq_ovf_word_t;

  // Word n sits at bits 32n+31:32n
  typedef struct packed {
    acq_ovf_word_t                 ovf;         // Word 7
    logic [NUM_CH-1:0][WORD_W-1:0] count;       // Words 6 to 3, channel 0 in word 3
    logic [WORD_W-1:0]             window_len;  // Word 2
    logic [WORD_W-1:0]             remaining;   // Word 1
    acq_ctrl_word_t                ctrl;        // Word 0
  } acq_status_t;

endpackage

/* axil_pkg.sv */
package axil_pkg;

  localparam int AXI_ADDR_W = 16;
  localparam int AXI_DATA_W = 32;
  localparam int ADDR_LSB   = $clog2(AXI_DATA_W / 8);  // Byte offset bits in an address

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Read address channel, master to slave
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arvalid;
  } axil_ar_t;

  // Read data channel, slave to master
  typedef struct packed {
    logic [AXI_DATA_W-1:0] rdata;
    axi_resp_e             rresp;
    logic                  rvalid;
  } axil_r_t;

endpackage

/* input_buffer.sv */
`timescale 1ns/1ps

module input_buffer #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  aclk,
  input  logic                  arst_n,
  input  logic [DATA_WIDTH-1:0] in_data,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic                  out_valid,
  input  logic                  out_ready
);

  logic [DATA_WIDTH-1:0] spare_data;
  logic                  spare_valid;
  logic                  main_load;

  assign in_ready  = !spare_valid;                 // Full only with both registers taken
  assign main_load = !out_valid || out_ready;      // Main register empty or draining

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_valid   <= 1'b0;
      spare_valid <= 1'b0;
    end
    else if (main_load)
    begin
      out_valid   <= spare_valid || in_valid;      // Spare goes first
      spare_valid <= 1'b0;
    end
    else if (in_valid && in_ready)
      spare_valid <= 1'b1;                         // Downstream stalled, park it
  end

  always_ff @(posedge aclk)
  begin
    if (main_load)
      out_data <= spare_valid ? spare_data : in_data;
    else if (in_valid && in_ready)
      spare_data <= in_data;
  end

  assert property (@(posedge aclk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("input_buffer: output changed while stalled");

endmodule

/* output_buffer.sv */
`timescale 1ns/1ps

module output_buffer #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  aclk,
  input  logic                  arst_n,
  input  logic [DATA_WIDTH-1:0] in_data,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic                  out_valid,
  input  logic                  out_ready
);

  logic [DATA_WIDTH-1:0] skid_data;
  logic                  skid_valid;
  logic                  advance;
  logic                  push;

  assign in_ready = !skid_valid;
  assign advance  = out_ready || !out_valid;       // Bus took the word or none is shown
  assign push     = in_valid && !skid_valid;

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end
    else
    begin
      if (advance)
        out_valid <= skid_valid || push;
      skid_valid <= !advance && (skid_valid || push);  // Hold the extra word under back-pressure
    end
  end

  always_ff @(posedge aclk)
  begin
    if (advance)
      out_data <= skid_valid ? skid_data : in_data;
    if (!advance && push)
      skid_data <= in_data;
  end

  // Once raised, valid waits for the bus
  assert property (@(posedge aclk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid)
    else $error("output_buffer: valid dropped before ready");

endmodule

/* axi_sts_register.sv */
`timescale 1ns/1ps

module axi_sts_register (
  input  logic                 aclk,
  input  logic                 arst_n,
  input  acq_pkg::acq_status_t sts_data,
  input  axil_pkg::axil_ar_t   s_axi_ar,
  output logic                 s_axi_arready,
  output axil_pkg::axil_r_t    s_axi_r,
  input  logic                 s_axi_rready,
  output logic                 s_axi_awready,
  output logic                 s_axi_wready,
  output logic                 s_axi_bvalid
);

  import acq_pkg::*;
  import axil_pkg::*;

  logic [STS_WORDS-1:0][AXI_DATA_W-1:0] words;
  logic [AXI_ADDR_W-1:0]                araddr_buf;
  logic                                 arvalid_buf;
  logic                                 rready_int;
  logic [STS_SEL_W-1:0]                 word_sel;
  logic [AXI_DATA_W-1:0]                rdata_mux;
  logic [AXI_DATA_W-1:0]                rdata_buf;
  logic                                 rvalid_buf;

  assign words     = sts_data;                           // Word 0 in the low bits
  assign word_sel  = araddr_buf[ADDR_LSB +: STS_SEL_W];  // Upper address bits wrap
  assign rdata_mux = words[word_sel];

  input_buffer #(
    .DATA_WIDTH(AXI_ADDR_W)
  ) i_ar_buf (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_data   (s_axi_ar.araddr),
    .in_valid  (s_axi_ar.arvalid),
    .in_ready  (s_axi_arready),
    .out_data  (araddr_buf),
    .out_valid (arvalid_buf),
    .out_ready (rready_int)
  );

  output_buffer #(
    .DATA_WIDTH(AXI_DATA_W)
  ) i_r_buf (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_data   (rdata_mux),
    .in_valid  (arvalid_buf),
    .in_ready  (rready_int),
    .out_data  (rdata_buf),
    .out_valid (rvalid_buf),
    .out_ready (s_axi_rready)
  );

  assign s_axi_r = '{rdata: rdata_buf, rresp: OKAY, rvalid: rvalid_buf};

  // Read-only bank
  assign s_axi_awready = 1'b0;
  assign s_axi_wready  = 1'b0;
  assign s_axi_bvalid  = 1'b0;

endmodule

/* acq_fsm.sv */
`timescale 1ns/1ps

module acq_fsm (
  input  logic                       aclk,
  input  logic                       arst_n,
  input  logic                       start,
  input  logic                       expire,
  output acq_pkg::acq_state_e        state,
  output logic                       load,
  output logic [acq_pkg::RUNS_W-1:0] run_count
);

  import acq_pkg::*;

  acq_state_e state_nxt;

  assign load = start && (state != RUN);           // Start ignored mid-window

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE, DONE:
      begin
        if (load)
          state_nxt = RUN;
      end
      RUN:
      begin
        if (expire)
          state_nxt = DONE;                        // Last window cycle
      end
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= IDLE;
      run_count <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (state == RUN && expire)
        run_count <= run_count + RUNS_W'(1);       // Wraps at 256
    end
  end

  // The timer only reaches 1 inside a window started by this FSM
  assert property (@(posedge aclk) disable iff (!arst_n) expire |-> state == RUN)
    else $error("acq_fsm: expire outside RUN");

endmodule

/* acq_timer.sv */
`timescale 1ns/1ps

module acq_timer (
  input  logic                      aclk,
  input  logic                      arst_n,
  input  logic                      load,
  input  logic [acq_pkg::WIN_W-1:0] window_len,
  output logic [acq_pkg::WIN_W-1:0] remaining,
  output logic                      expire
);

  import acq_pkg::*;

  assign expire = (remaining == WIN_W'(1));        // Last cycle of the window

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
      remaining <= '0;
    else if (load)
      remaining <= (window_len == '0) ? WIN_W'(1) : window_len;  // Zero runs one cycle
    else if (remaining != '0)
      remaining <= remaining - WIN_W'(1);
  end

  // Without a load the count only goes down, so it never wraps past zero
  assert property (@(posedge aclk) disable iff (!arst_n)
    !load |=> remaining <= $past(remaining))
    else $error("acq_timer: counted below zero");

endmodule

/* event_counters.sv */
`timescale 1ns/1ps

module event_counters (
  input  logic                                            aclk,
  input  logic                                            arst_n,
  input  logic                                            clear,
  input  logic                                            enable,
  input  logic [acq_pkg::NUM_CH-1:0]                      events,
  output logic [acq_pkg::NUM_CH-1:0][acq_pkg::CNT_W-1:0]  counts,
  output logic [acq_pkg::NUM_CH-1:0]                      ovf
);

  import acq_pkg::*;

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      counts <= '0;
      ovf    <= '0;
    end
    else if (clear)
    begin
      counts <= '0;                                // New window
      ovf    <= '0;
    end
    else if (enable)
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
        if (events[ch])
        begin
          if (counts[ch] == '1)
            ovf[ch] <= 1'b1;                       // Event lost at full scale
          else
            counts[ch] <= counts[ch] + CNT_W'(1);
        end
      end
    end
  end

endmodule

/* acq_status_top.sv */
`timescale 1ns/1ps

module acq_status_top (
  input  logic                       aclk,
  input  logic                       arst_n,
  input  logic                       start,
  input  logic [acq_pkg::WIN_W-1:0]  window_len,
  input  logic [acq_pkg::NUM_CH-1:0] events,
  input  axil_pkg::axil_ar_t         s_axi_ar,
  output logic                       s_axi_arready,
  output axil_pkg::axil_r_t          s_axi_r,
  input  logic                       s_axi_rready,
  output logic                       s_axi_awready,
  output logic                       s_axi_wready,
  output logic                       s_axi_bvalid
);

  import acq_pkg::*;

  acq_state_e                   state;
  logic                         load;
  logic                         expire;
  logic                         enable;
  logic [RUNS_W-1:0]            run_count;
  logic [WIN_W-1:0]             remaining;
  logic [WIN_W-1:0]             win_len_q;
  logic [NUM_CH-1:0][CNT_W-1:0] counts;
  logic [NUM_CH-1:0]            ovf;
  acq_status_t                  sts_data;

  assign enable = (state == RUN);                  // Count only inside the window

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
      win_len_q <= '0;
    else if (load)
      win_len_q <= window_len;                     // As programmed, zero kept
  end

  always_comb
  begin
    sts_data                = '0;
    sts_data.ctrl.state     = state;
    sts_data.ctrl.run_count = run_count;
    sts_data.remaining      = WORD_W'(remaining);
    sts_data.window_len     = WORD_W'(win_len_q);
    for (int ch = 0; ch < NUM_CH; ch++)
      sts_data.count[ch] = WORD_W'(counts[ch]);
    sts_data.ovf.flags      = ovf;
  end

  acq_fsm i_acq_fsm (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .start     (start),
    .expire    (expire),
    .state     (state),
    .load      (load),
    .run_count (run_count)
  );

  acq_timer i_acq_timer (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .load       (load),
    .window_len (window_len),
    .remaining  (remaining),
    .expire     (expire)
  );

  event_counters i_event_counters (
    .aclk   (aclk),
    .arst_n (arst_n),
    .clear  (load),
    .enable (enable),
    .events (events),
    .counts (counts),
    .ovf    (ovf)
  );

  axi_sts_register i_axi_sts_register (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .sts_data      (sts_data),
    .s_axi_ar      (s_axi_ar),
    .s_axi_arready (s_axi_arready),
    .s_axi_r       (s_axi_r),
    .s_axi_rready  (s_axi_rready),
    .s_axi_awready (s_axi_awready),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bvalid  (s_axi_bvalid)
  );

endmodule

/* tb_acq_status.sv */
`timescale 1ns/1ps

module tb_acq_status;

  import acq_pkg::*;
  import axil_pkg::*;

  logic              aclk;
  logic              arst_n;
  logic              start;
  logic [WIN_W-1:0]  window_len;
  logic [NUM_CH-1:0] events;
  axil_ar_t          s_axi_ar;
  logic              s_axi_arready;
  axil_r_t           s_axi_r;
  logic              s_axi_rready;
  logic              s_axi_awready;
  logic              s_axi_wready;
  logic              s_axi_bvalid;

  integer            seed = 32'hc9cd;
  int                budget_cycles = 0;
  int                win_lens[8];                  // 0 to 5 random, 6 restart test, 7 saturation
  int                model_cnt[NUM_CH];
  logic [NUM_CH-1:0] model_ovf;
  int                model_runs;
  int                model_win;
  acq_state_e        model_state;

  acq_status_top i_acq_status_top (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .start         (start),
    .window_len    (window_len),
    .events        (events),
    .s_axi_ar      (s_axi_ar),
    .s_axi_arready (s_axi_arready),
    .s_axi_r       (s_axi_r),
    .s_axi_rready  (s_axi_rready),
    .s_axi_awready (s_axi_awready),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bvalid  (s_axi_bvalid)
  );

  initial
    aclk = 1'b0;
  always #5 aclk = ~aclk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input logic [AXI_DATA_W-1:0] got, input logic [AXI_DATA_W-1:0] exp,
                            input string what);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_resp(input axi_resp_e got, input axi_resp_e exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t ns: rresp %s, expected %s", $time, got.name(), exp.name()));
  endtask

  task automatic check_state(input acq_state_e got, input acq_state_e exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t ns: state %s, expected %s", $time, got.name(), exp.name()));
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % 32'(hi - lo + 1));
  endfunction

  // Status word as the register map defines it
  function automatic logic [AXI_DATA_W-1:0] expected_word(input int idx);
    logic [AXI_DATA_W-1:0] w;
    case (idx)
      0:          w = (AXI_DATA_W'(model_runs % 256) << 16) | AXI_DATA_W'(model_state);
      2:          w = AXI_DATA_W'(model_win);
      3, 4, 5, 6: w = AXI_DATA_W'(model_cnt[idx-3]);
      7:          w = AXI_DATA_W'(model_ovf);
      default:    w = '0;                            // Remaining is zero once the window ends
    endcase
    return w;
  endfunction

  task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, input int stall,
                          output logic [AXI_DATA_W-1:0] data, output axi_resp_e resp);
    @(posedge aclk);
    s_axi_ar.araddr  <= addr;
    s_axi_ar.arvalid <= 1'b1;
    @(negedge aclk);
    while (!s_axi_arready)
      @(negedge aclk);
    @(posedge aclk);                               // Address taken on this edge
    s_axi_ar.arvalid <= 1'b0;
    @(negedge aclk);
    while (!s_axi_r.rvalid)
      @(negedge aclk);
    data = s_axi_r.rdata;
    resp = s_axi_r.rresp;
    repeat (stall)
    begin
      @(negedge aclk);
      if (!s_axi_r.rvalid)
        fail_run("rvalid dropped while rready was low");
      check_word(s_axi_r.rdata, data, "rdata under back-pressure");
    end
    @(posedge aclk);
    s_axi_rready <= 1'b1;
    @(posedge aclk);                               // Beat accepted here
    s_axi_rready <= 1'b0;
  endtask

  task automatic read_all_words();
    logic [AXI_DATA_W-1:0] data;
    axi_resp_e             resp;
    for (int w = 0; w < STS_WORDS; w++)
    begin
      axi_read(AXI_ADDR_W'(w * 4), rand_range(0, 7), data, resp);
      check_resp(resp, OKAY);
      if (w == 0)
        check_state(acq_state_e'(data[1:0]), model_state);
      check_word(data, expected_word(w), $sformatf("status word %0d", w));
    end
  endtask

  // One window, optionally with a second start mid-run or channel 0 held high
  task automatic run_window(input int len, input bit extra_start, input bit hold_ch0);
    logic [NUM_CH-1:0] ev;
    @(posedge aclk);
    window_len <= WIN_W'(len);
    start      <= 1'b1;
    model_ovf = '0;
    model_win = len;
    for (int ch = 0; ch < NUM_CH; ch++)
      model_cnt[ch] = 0;
    for (int i = 0; i < len; i++)
    begin
      @(posedge aclk);
      ev = NUM_CH'($random(seed));
      if (hold_ch0)
        ev[0] = 1'b1;
      start  <= extra_start && (i == len / 2);     // Lands mid-window, must be ignored
      events <= ev;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
        if (ev[ch] && model_cnt[ch] == 65535)
          model_ovf[ch] = 1'b1;
        else if (ev[ch])
          model_cnt[ch]++;
      end
    end
    @(posedge aclk);
    events <= '0;
    start  <= 1'b0;
    model_runs++;
    model_state = DONE;
  endtask

  initial
  begin : watchdog
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge aclk);
    fail_run("Timeout: the tests did not complete within the cycle budget");
  end

  always @(negedge aclk)
  begin
    if (arst_n && (s_axi_awready || s_axi_wready || s_axi_bvalid))
      fail_run("A write channel handshake signal was raised on a read-only port");
  end

  initial
  begin : main
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_ADDR_W-1:0] addr;
    axi_resp_e             resp;
    int                    total;
    arst_n       <= 1'b0;
    start        <= 1'b0;
    window_len   <= '0;
    events       <= '0;
    s_axi_ar     <= '0;
    s_axi_rready <= 1'b0;
    model_runs  = 0;
    model_win   = 0;
    model_ovf   = '0;
    model_state = IDLE;
    for (int ch = 0; ch < NUM_CH; ch++)
      model_cnt[ch] = 0;
    total = 0;
    for (int i = 0; i < 6; i++)
      win_lens[i] = rand_range(1, 300);
    win_lens[6] = rand_range(4, 300);
    win_lens[7] = 70000;
    foreach (win_lens[i])
      total += win_lens[i];
    budget_cycles = total + 2000;
    repeat (4) @(posedge aclk);
    arst_n <= 1'b1;
    @(negedge aclk);
    if (!s_axi_arready || s_axi_r.rvalid)
      fail_run("Read channel not idle after reset");
    read_all_words();                              // Reset values, state IDLE
    for (int i = 0; i < 6; i++)
    begin
      run_window(win_lens[i], 1'b0, 1'b0);
      read_all_words();
    end
    run_window(win_lens[6], 1'b1, 1'b0);
    read_all_words();
    run_window(win_lens[7], 1'b0, 1'b1);
    read_all_words();
    for (int i = 0; i < 12; i++)
    begin
      addr = AXI_ADDR_W'(32 + 4 * rand_range(0, 16000));
      axi_read(addr, rand_range(0, 15), data, resp);
      check_resp(resp, OKAY);
      check_word(data, expected_word(int'(addr[4:2])), $sformatf("wrapped address %h", addr));
    end
    $display("Regression passed");
    $finish;
  end

endmodule

/* sources.f */
acq_pkg.sv
axil_pkg.sv
input_buffer.sv
output_buffer.sv
axi_sts_register.sv
acq_fsm.sv
acq_timer.sv
event_counters.sv
acq_status_top.sv
tb_acq_status.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the acquisition testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_acq_status \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
